// File: vlog.f
src/rf_pkg.sv
src/rf_clock_gate.sv
src/rf_strobe_check.sv
src/rf_latch_regfile.sv
src/rf_top.sv
dv/rf_top_asserts.sv
dv/tb_rf_top.sv

// File: Makefile
# Verilator build and run for the register file testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_rf_top
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
RUN_FLAGS ?= +verilator+error+limit+100
PASS_MSG  := SIMULATION PASSED

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Output is shown and then searched for the pass message
run: compile
	@out="$$($(BIN) $(RUN_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/tb_rf_top.sv
// ==========================================================
// Directed testbench for the register file subsystem. Drives
// inputs on the falling edge and checks reads against a
// reference model before the next falling edge.
// ==========================================================

`timescale 1ns/100ps

module tb_rf_top;

  import rf_pkg::*;

  localparam int unsigned CLK_PERIOD      = 40;
  localparam int unsigned RESET_CYCLES    = 4;
  // Tests need about 150 cycles, so this leaves a wide margin
  localparam int unsigned WATCHDOG_CYCLES = 2000;

  logic                      clk_int;
  logic                      rst_ni;
  logic                      test_en;
  logic                      dummy_instr;
  logic [RF_PORT_ADDR_W-1:0] raddr_a;
  logic [RF_PORT_ADDR_W-1:0] raddr_b;
  logic [RF_PORT_ADDR_W-1:0] waddr;
  logic [RF_DATA_W-1:0]      rdata_a;
  logic [RF_DATA_W-1:0]      rdata_b;
  logic [RF_DATA_W-1:0]      wdata;
  logic                      we;
  logic                      err;

  // Reference contents and decoy register 0 model
  logic [RF_DATA_W-1:0] ref_mem [RF_NUM_WORDS];
  logic [RF_DATA_W-1:0] decoy_r0;
  logic [31:0]          rng_state;
  int unsigned          err_count;
  int unsigned          check_count;
  int unsigned          test_count;
  int unsigned          test_errs;

  rf_top dut0 (
    .clk_int       (clk_int),
    .rst_ni        (rst_ni),
    .test_en_i     (test_en),
    .dummy_instr_i (dummy_instr),
    .raddr_a_i     (raddr_a),
    .rdata_a_o     (rdata_a),
    .raddr_b_i     (raddr_b),
    .rdata_b_o     (rdata_b),
    .waddr_i       (waddr),
    .wdata_i       (wdata),
    .we_i          (we),
    .err_o         (err)
  );

  initial begin
    clk_int = 1'b0;
    forever begin
      #(CLK_PERIOD / 2);
      clk_int = ~clk_int;
    end
  end

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // Any index except register 0
  function automatic logic [RF_PORT_ADDR_W-1:0] rand_word_addr();
    return RF_PORT_ADDR_W'(1 + lcg_next() % (RF_NUM_WORDS - 1));
  endfunction

  // Register 0 rules applied on top of the reference array
  function automatic logic [RF_DATA_W-1:0] expected_read(input logic [RF_PORT_ADDR_W-1:0] addr,
                                                         input logic dummy);
    logic [RF_ADDR_W-1:0] idx;
    idx = addr[RF_ADDR_W-1:0];
    if (idx == '0) begin
      return (dummy && RF_DUMMY_EN) ? decoy_r0 : RF_ZERO_VAL;
    end
    return ref_mem[idx];
  endfunction

  task automatic check_value(input string name, input logic [RF_DATA_W-1:0] exp_val,
                             input logic [RF_DATA_W-1:0] act_val);
    check_count++;
    if (act_val !== exp_val) begin
      $display("ERROR %s: expected %h, got %h at %0t", name, exp_val, act_val, $time);
      err_count++;
      test_errs++;
    end
  endtask

  // New inputs right after the falling edge
  task automatic drive(input logic w_en, input logic [RF_PORT_ADDR_W-1:0] w_addr,
                       input logic [RF_DATA_W-1:0] w_data, input logic dummy,
                       input logic [RF_PORT_ADDR_W-1:0] ra, input logic [RF_PORT_ADDR_W-1:0] rb);
    @(negedge clk_int);
    we          = w_en;
    waddr       = w_addr;
    wdata       = w_data;
    dummy_instr = dummy;
    raddr_a     = ra;
    raddr_b     = rb;
  endtask

  // Past the rising edge, before the next falling edge
  task automatic settle();
    @(posedge clk_int);
    #(CLK_PERIOD / 4);
  endtask

  task automatic check_reads(input logic dummy);
    check_value("rdata_a_o", expected_read(raddr_a, dummy), rdata_a);
    check_value("rdata_b_o", expected_read(raddr_b, dummy), rdata_b);
  endtask

  task automatic report_test(input string name);
    test_count++;
    $display("%-16s %s, %0d errors", name, (test_errs == 0) ? "pass" : "fail", test_errs);
    test_errs = 0;
  endtask

  task automatic test_reset_state();
    logic [RF_DATA_W-1:0] data;
    data = lcg_next();
    check_value("err_o", '0, RF_DATA_W'(err));
    drive(1'b0, '0, '0, 1'b0, '0, '0);
    settle();
    check_reads(1'b0);
    // Plain write to register 0 is dropped
    drive(1'b1, '0, data, 1'b0, '0, '0);
    drive(1'b0, '0, '0, 1'b0, '0, '0);
    settle();
    check_reads(1'b0);
    check_value("err_o", '0, RF_DATA_W'(err));
    report_test("reset_state");
  endtask

  task automatic test_fill_readback();
    logic [RF_DATA_W-1:0] data;
    for (int a = 1; a < RF_NUM_WORDS; a++) begin
      data = lcg_next();
      drive(1'b1, RF_PORT_ADDR_W'(a), data, 1'b0, '0, '0);
      ref_mem[a] = data;
    end
    for (int a = 1; a < RF_NUM_WORDS; a++) begin
      // Port B one ahead, wrapping onto register 0
      drive(1'b0, '0, '0, 1'b0, RF_PORT_ADDR_W'(a), RF_PORT_ADDR_W'((a + 1) % RF_NUM_WORDS));
      settle();
      check_reads(1'b0);
    end
    report_test("fill_readback");
  endtask

  task automatic test_write_timing();
    logic [RF_PORT_ADDR_W-1:0] addr;
    logic [RF_DATA_W-1:0]      data;
    for (int n = 0; n < 4; n++) begin
      addr = rand_word_addr();
      data = lcg_next();
      drive(1'b1, addr, data, 1'b0, addr, addr);
      #(CLK_PERIOD / 4);
      // Before the strobe edge, old contents
      check_reads(1'b0);
      settle();
      ref_mem[addr[RF_ADDR_W-1:0]] = data;
      check_reads(1'b0);
    end
    drive(1'b0, '0, '0, 1'b0, '0, '0);
    report_test("write_timing");
  endtask

  task automatic test_no_strobe();
    logic [RF_PORT_ADDR_W-1:0] addr;
    logic [RF_DATA_W-1:0]      data;
    logic [RF_PORT_ADDR_W-1:0] ra;
    logic [RF_PORT_ADDR_W-1:0] rb;
    for (int n = 0; n < 8; n++) begin
      addr = rand_word_addr();
      data = lcg_next();
      ra   = RF_PORT_ADDR_W'(lcg_next() % RF_NUM_WORDS);
      rb   = addr;
      drive(1'b0, addr, data, 1'b0, ra, rb);
      settle();
      check_reads(1'b0);
      check_value("err_o", '0, RF_DATA_W'(err));
    end
    report_test("no_strobe");
  endtask

  task automatic test_decoy_r0();
    logic [RF_DATA_W-1:0] data;
    data = lcg_next();
    drive(1'b1, '0, data, 1'b1, '0, '0);
    if (RF_DUMMY_EN) begin
      decoy_r0 = data;
    end
    drive(1'b0, '0, '0, 1'b1, '0, 5'd1);
    settle();
    check_reads(1'b1);
    drive(1'b0, '0, '0, 1'b0, '0, '0);
    settle();
    check_reads(1'b0);
    // Decoy on port B while port A sweeps the real words
    for (int a = 1; a < RF_NUM_WORDS; a++) begin
      drive(1'b0, '0, '0, 1'b1, RF_PORT_ADDR_W'(a), '0);
      settle();
      check_reads(1'b1);
    end
    report_test("decoy_r0");
  endtask

  task automatic test_back_to_back();
    logic [RF_PORT_ADDR_W-1:0] a0;
    logic [RF_PORT_ADDR_W-1:0] a1;
    logic [RF_PORT_ADDR_W-1:0] addr;
    logic [RF_DATA_W-1:0]      data;
    a0 = rand_word_addr();
    a1 = RF_PORT_ADDR_W'(a0 % (RF_NUM_WORDS - 1) + 1);
    for (int n = 0; n < 8; n++) begin
      addr = n[0] ? a1 : a0;
      data = lcg_next();
      drive(1'b1, addr, data, 1'b0, addr, n[0] ? a0 : a1);
      settle();
      ref_mem[addr[RF_ADDR_W-1:0]] = data;
      check_reads(1'b0);
      check_value("err_o", '0, RF_DATA_W'(err));
    end
    drive(1'b0, '0, '0, 1'b0, '0, '0);
    report_test("back_to_back");
  endtask

  // Strobe fault watch across every test
  always @(posedge clk_int) begin
    if (rst_ni && err !== 1'b0) begin
      $display("ERROR err_o: expected 0, got %h at %0t", err, $time);
      err_count++;
      test_errs++;
    end
  end

  initial begin
    rst_ni      = 1'b0;
    test_en     = 1'b0;
    dummy_instr = 1'b0;
    raddr_a     = '0;
    raddr_b     = '0;
    waddr       = '0;
    wdata       = '0;
    we          = 1'b0;
    decoy_r0    = RF_ZERO_VAL;
    rng_state   = 32'h2043ef0a;
    err_count   = 0;
    check_count = 0;
    test_count  = 0;
    test_errs   = 0;
    repeat (RESET_CYCLES) @(posedge clk_int);
    @(negedge clk_int);
    rst_ni = 1'b1;
    test_reset_state();
    test_fill_readback();
    test_write_timing();
    test_no_strobe();
    test_decoy_r0();
    test_back_to_back();
    // Failed concurrent assertions in the bound checker
    err_count += dut0.u_asserts.fail_count;
    $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: dv/rf_top_asserts.sv
// ==========================================================
// Concurrent checks on the register file subsystem, bound
// into rf_top at the end of this file. The testbench adds
// the failure count to its error total.
// ==========================================================

`timescale 1ns/100ps

module rf_top_asserts (
  input logic                              clk_int,
  input logic                              rst_ni,
  input logic                              dummy_instr_i,
  input logic [rf_pkg::RF_PORT_ADDR_W-1:0] raddr_a_i,
  input logic [rf_pkg::RF_PORT_ADDR_W-1:0] raddr_b_i,
  input logic [rf_pkg::RF_DATA_W-1:0]      rdata_a_i,
  input logic [rf_pkg::RF_DATA_W-1:0]      rdata_b_i,
  input logic                              err_i
);

  import rf_pkg::*;

  logic r0_read_a;
  logic r0_read_b;

  // Number of assertion failures so far
  int unsigned fail_count = 0;

  // Real instruction reading register 0
  assign r0_read_a = (raddr_a_i[RF_ADDR_W-1:0] == '0) && !dummy_instr_i;
  assign r0_read_b = (raddr_b_i[RF_ADDR_W-1:0] == '0) && !dummy_instr_i;

  a_no_fault: assert property (@(posedge clk_int) disable iff (!rst_ni) !err_i)
    else begin
      fail_count++;
      $error("err_o raised outside reset");
    end

  a_fault_low_in_reset: assert property (@(posedge clk_int) !rst_ni |-> !err_i)
    else begin
      fail_count++;
      $error("err_o high while reset is active");
    end

  a_r0_zero_a: assert property (@(posedge clk_int) disable iff (!rst_ni)
                                r0_read_a |-> rdata_a_i == RF_ZERO_VAL)
    else begin
      fail_count++;
      $error("register 0 read on port A is not zero");
    end

  a_r0_zero_b: assert property (@(posedge clk_int) disable iff (!rst_ni)
                                r0_read_b |-> rdata_b_i == RF_ZERO_VAL)
    else begin
      fail_count++;
      $error("register 0 read on port B is not zero");
    end

endmodule

bind rf_top rf_top_asserts u_asserts (
  .clk_int       (clk_int),
  .rst_ni        (rst_ni),
  .dummy_instr_i (dummy_instr_i),
  .raddr_a_i     (raddr_a_i),
  .raddr_b_i     (raddr_b_i),
  .rdata_a_i     (rdata_a_o),
  .rdata_b_i     (rdata_b_o),
  .err_i         (err_o)
);

// File: src/rf_top.sv
// ==========================================================
// Register file subsystem boundary as seen by the core.
// Wires the latch register file out to the core ports.
// ==========================================================

`timescale 1ns/100ps

module rf_top (
  input  logic                              clk_int,
  input  logic                              rst_ni,
  input  logic                              test_en_i,
  input  logic                              dummy_instr_i,
  input  logic [rf_pkg::RF_PORT_ADDR_W-1:0] raddr_a_i,
  output logic [rf_pkg::RF_DATA_W-1:0]      rdata_a_o,
  input  logic [rf_pkg::RF_PORT_ADDR_W-1:0] raddr_b_i,
  output logic [rf_pkg::RF_DATA_W-1:0]      rdata_b_o,
  input  logic [rf_pkg::RF_PORT_ADDR_W-1:0] waddr_i,
  input  logic [rf_pkg::RF_DATA_W-1:0]      wdata_i,
  input  logic                              we_i,
  output logic                              err_o
);

  // Scan enable passes straight to every clock gate
  rf_latch_regfile u_regfile (
    .clk_int       (clk_int),
    .rst_ni        (rst_ni),
    .test_en_i     (test_en_i),
    .dummy_instr_i (dummy_instr_i),
    // Read port A
    .raddr_a_i     (raddr_a_i),
    .rdata_a_o     (rdata_a_o),
    // Read port B
    .raddr_b_i     (raddr_b_i),
    .rdata_b_o     (rdata_b_o),
    // Single write port
    .waddr_i       (waddr_i),
    .wdata_i       (wdata_i),
    .we_i          (we_i),
    // Strobe fault
    .err_o         (err_o)
  );

endmodule

// File: src/rf_latch_regfile.sv
// ==========================================================
// Latch-based integer register file with two combinational
// read ports and one write port. Each word has its own clock
// gate fed from a globally gated write clock.
// ==========================================================

`timescale 1ns/100ps

module rf_latch_regfile (
  input  logic                              clk_int,
  input  logic                              rst_ni,
  input  logic                              test_en_i,
  input  logic                              dummy_instr_i,
  input  logic [rf_pkg::RF_PORT_ADDR_W-1:0] raddr_a_i,
  output logic [rf_pkg::RF_DATA_W-1:0]      rdata_a_o,
  input  logic [rf_pkg::RF_PORT_ADDR_W-1:0] raddr_b_i,
  output logic [rf_pkg::RF_DATA_W-1:0]      rdata_b_o,
  input  logic [rf_pkg::RF_PORT_ADDR_W-1:0] waddr_i,
  input  logic [rf_pkg::RF_DATA_W-1:0]      wdata_i,
  input  logic                              we_i,
  output logic                              err_o
);

  import rf_pkg::*;

  // Read view of all words, register 0 included
  logic [RF_DATA_W-1:0]    mem [RF_NUM_WORDS];

  logic [RF_ADDR_W-1:0]    raddr_a_int;
  logic [RF_ADDR_W-1:0]    raddr_b_int;
  logic [RF_ADDR_W-1:0]    waddr_int;

  logic                    clk_wr;
  logic [RF_DATA_W-1:0]    wdata_q;
  logic [RF_NUM_WORDS-1:1] waddr_onehot;
  logic [RF_NUM_WORDS-1:1] word_clk;

  // Drop unused upper address bits
  assign raddr_a_int = raddr_a_i[RF_ADDR_W-1:0];
  assign raddr_b_int = raddr_b_i[RF_ADDR_W-1:0];
  assign waddr_int   = waddr_i[RF_ADDR_W-1:0];

  if (RF_RV32E) begin : g_rv32e_addr
    // MSB of each port is ignored with 16 registers
    logic unused_addr_msb;
    assign unused_addr_msb = raddr_a_i[RF_PORT_ADDR_W-1] ^ raddr_b_i[RF_PORT_ADDR_W-1] ^
                             waddr_i[RF_PORT_ADDR_W-1];
  end

  // Combinational reads
  assign rdata_a_o = mem[raddr_a_int];
  assign rdata_b_o = mem[raddr_b_int];

  // Global gate, only pulses in write cycles
  rf_clock_gate u_cg_global (
    .clk_i     (clk_int),
    .en_i      (we_i),
    .test_en_i (test_en_i),
    .clk_o     (clk_wr)
  );

  // Sample write data on the gated clock
  always_ff @(posedge clk_wr or negedge rst_ni) begin
    if (!rst_ni) begin
      wdata_q <= RF_ZERO_VAL;
    end else begin
      wdata_q <= wdata_i;
    end
  end

  // One-hot strobes for words 1 and up
  always_comb begin
    for (int i = 1; i < RF_NUM_WORDS; i++) begin
      waddr_onehot[i] = we_i && (waddr_int == RF_ADDR_W'(i));
    end
  end

  // Spurious strobe detection
  rf_strobe_check u_strobe_check (
    .oh_i   (waddr_onehot),
    .addr_i (waddr_int),
    .en_i   (we_i),
    .err_o  (err_o)
  );

  // Per-word gate and storage latch
  for (genvar w = 1; w < RF_NUM_WORDS; w++) begin : g_word
    logic [RF_DATA_W-1:0] word_q;

    rf_clock_gate u_cg_word (
      .clk_i     (clk_wr),
      .en_i      (waddr_onehot[w]),
      .test_en_i (test_en_i),
      .clk_o     (word_clk[w])
    );

    // Open during the high phase of the word clock
    always_latch begin
      if (word_clk[w]) begin
        word_q <= wdata_q;
      end
    end

    assign mem[w] = word_q;
  end

  if (RF_DUMMY_EN) begin : g_dummy_r0
    logic                 we_r0_dummy;
    logic                 r0_clk;
    logic [RF_DATA_W-1:0] r0_q;

    // Dummy instructions always target address 0
    assign we_r0_dummy = we_i & dummy_instr_i;

    rf_clock_gate u_cg_r0 (
      .clk_i     (clk_wr),
      .en_i      (we_r0_dummy),
      .test_en_i (test_en_i),
      .clk_o     (r0_clk)
    );

    always_latch begin
      if (r0_clk) begin
        r0_q <= wdata_q;
      end
    end

    // Decoy visible only to dummy instructions
    assign mem[0] = dummy_instr_i ? r0_q : RF_ZERO_VAL;
  end else begin : g_plain_r0
    logic unused_dummy_instr;
    assign unused_dummy_instr = dummy_instr_i;

    assign mem[0] = RF_ZERO_VAL;
  end

endmodule

// File: src/rf_strobe_check.sv
// ==========================================================
// Consistency check on the decoded write strobes. Flags more
// than one strobe, a strobe without write enable, or a strobe
// that does not match the write address. Purely combinational.
// ==========================================================

`timescale 1ns/100ps

module rf_strobe_check (
  input  logic [rf_pkg::RF_NUM_WORDS-1:1] oh_i,
  input  logic [rf_pkg::RF_ADDR_W-1:0]    addr_i,
  input  logic                            en_i,
  output logic                            err_o
);

  import rf_pkg::*;

  logic                 any_hit;
  logic                 multi_hit;
  logic [RF_ADDR_W-1:0] hit_idx;
  logic                 idx_mismatch;

  // Walk the strobes once
  always_comb begin
    any_hit   = 1'b0;
    multi_hit = 1'b0;
    hit_idx   = '0;
    for (int i = 1; i < RF_NUM_WORDS; i++) begin
      if (oh_i[i]) begin
        // Second set bit means a multiple hit
        multi_hit = multi_hit | any_hit;
        any_hit   = 1'b1;
        // OR-encoding is exact for a true one-hot
        hit_idx   = hit_idx | RF_ADDR_W'(i);
      end
    end
  end

  // Index only meaningful with exactly one strobe
  assign idx_mismatch = any_hit & ~multi_hit & (hit_idx != addr_i);

  // Strobe while write enable is low is spurious
  assign err_o = multi_hit | (any_hit & ~en_i) | idx_mismatch;

endmodule

// File: src/rf_clock_gate.sv
// ==========================================================
// Behavioural integrated clock gate. Enable is captured by a
// latch transparent while the clock is low, so the gated
// clock never glitches. Test enable forces the gate open.
// ==========================================================

`timescale 1ns/100ps

module rf_clock_gate (
  input  logic clk_i,
  input  logic en_i,
  input  logic test_en_i,
  output logic clk_o
);

  // Enable held stable through the high phase
  logic en_latch;

  // Transparent only in the low phase of the clock
  always_latch begin
    if (!clk_i) begin
      en_latch <= en_i | test_en_i;
    end
  end

  // AND with latched enable gives clean pulses
  assign clk_o = clk_i & en_latch;

endmodule

// File: src/rf_pkg.sv
// ==========================================================
// Build-wide constants for the latch-based register file.
// Modules import this package inside their body and use
// scoped names for widths in their port lists.
// ==========================================================

package rf_pkg;

  // Embedded base ISA with 16 registers instead of 32
  localparam bit RF_RV32E = 1'b0;

  // Index width used inside the register file
  localparam int unsigned RF_ADDR_W = RF_RV32E ? 4 : 5;

  // Address ports always carry the full RISC-V register index
  localparam int unsigned RF_PORT_ADDR_W = 5;

  // Word count including register 0
  localparam int unsigned RF_NUM_WORDS = 2 ** RF_ADDR_W;

  // Register width
  localparam int unsigned RF_DATA_W = 32;

  // Value returned by register 0 for real instructions,
  // also the reset value of the sampled write data
  localparam logic [RF_DATA_W-1:0] RF_ZERO_VAL = '0;

  // Decoy register 0, only reachable by dummy instructions
  localparam bit RF_DUMMY_EN = 1'b1;

endpackage
